// ==== dv/dpCoreChecker.sv ====
// Timing and reset assertions for dpCore, attached to every dpCore instance by bind
`timescale 1ns/1ps

module dpCoreChecker (
  input logic           Clk,
  input logic           Reset,
  input logic           Issue,
  input logic           UpdateFlags,
  input dpPkg::regIdx_t Dest,
  input logic           ResultValid,
  input dpPkg::regIdx_t ResultDest,
  input dpPkg::flags_t  Flags
);

  resetQuiet: assert property (@(posedge Clk) Reset |-> !ResultValid)
    else $error("ResultValid high while reset is held");

  // Fixed latency of one cycle
  validFollowsIssue: assert property (@(posedge Clk) disable iff (Reset)
    Issue |=> ResultValid)
    else $error("No ResultValid in the cycle after Issue");

  noSpuriousValid: assert property (@(posedge Clk) disable iff (Reset)
    !Issue |=> !ResultValid)
    else $error("ResultValid without an Issue in the cycle before");

  destFollowsIssue: assert property (@(posedge Clk) disable iff (Reset)
    Issue |=> (ResultDest == $past(Dest)))
    else $error("ResultDest differs from the issued Dest");

  flagsHeld: assert property (@(posedge Clk) disable iff (Reset)
    !(Issue && UpdateFlags) |=> $stable(Flags))
    else $error("Flags changed without a flag-updating Issue");

endmodule

bind dpCore dpCoreChecker timingChecks (
  .Clk         (Clk),
  .Reset       (Reset),
  .Issue       (Issue),
  .UpdateFlags (UpdateFlags),
  .Dest        (Dest),
  .ResultValid (ResultValid),
  .ResultDest  (ResultDest),
  .Flags       (Flags)
);

// ==== dv/dpCoreTb.sv ====
// Testbench for dpCore with random and directed commands checked against a register model
// Top module of the simulation with the timing checker bound in from its own file
`timescale 1ns/1ps

module dpCoreTb;

  logic             Clk;
  logic             Reset;
  logic             Issue;
  logic             WriteBack;
  logic             UpdateFlags;
  dpPkg::aluOp_t    AluOp;
  dpPkg::addrMode_t AddrMode;
  dpPkg::imm_t      Imm;
  dpPkg::regIdx_t   SrcA;
  dpPkg::regIdx_t   SrcB;
  dpPkg::regIdx_t   Dest;
  logic             ResultValid;
  dpPkg::word_t     Result;
  dpPkg::regIdx_t   ResultDest;
  dpPkg::flags_t    Flags;

  dpPkg::word_t   modelRegs [dpPkg::NumRegs]; // Architectural register state
  dpPkg::flags_t  modelFlags;
  logic           expValid;
  dpPkg::word_t   expResult;
  dpPkg::regIdx_t expDest;
  dpPkg::aluOp_t  opList [9];
  integer         seed;
  int             errorCount;
  int             checkCount;
  logic [31:0]    r;
  logic [4:0]     amt;

  dpCore uut (.*);

  initial begin
    Clk = 1'b0;
    forever #10 Clk = ~Clk;
  end

  initial begin
    #200000;
    $display("Simulation timed out");
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  function automatic dpPkg::word_t rotRight(input dpPkg::word_t v, input int n);
    return (n == 0) ? v : ((v >> n) | (v << (32 - n)));
  endfunction

  // Second operand by addressing mode
  function automatic dpPkg::word_t operandModel(input dpPkg::word_t rm, input dpPkg::imm_t imm,
                                                input dpPkg::addrMode_t mode);
    int n;
    n = int'(imm[11:7]);
    case (mode)
      dpPkg::AmRotImm:  return rotRight({24'b0, imm[7:0]}, 2 * int'(imm[11:8]));
      dpPkg::AmReg:     return rm;
      dpPkg::AmZeroImm: return {20'b0, imm};
      default: begin
        case (imm[6:5])
          dpPkg::ShLsl: return rm << n;
          dpPkg::ShLsr: return rm >> n;
          dpPkg::ShAsr: return (rm >> n) | (rm[31] ? ~(32'hFFFF_FFFF >> n) : 32'h0);
          default:      return rotRight(rm, n);
        endcase
      end
    endcase
  endfunction

  // Signed result that no longer fits in 32 bits
  function automatic logic wideOverflow(input longint s);
    return s != longint'($signed(s[31:0]));
  endfunction

  task automatic aluModel(input dpPkg::aluOp_t op, input dpPkg::word_t a, input dpPkg::word_t b,
                          output dpPkg::word_t res, output dpPkg::flags_t fl);
    longint sa;
    longint sb;
    logic   c;
    logic   v;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    c  = modelFlags[dpPkg::FlagC]; // Logical ops keep C and V
    v  = modelFlags[dpPkg::FlagV];
    case (op)
      dpPkg::OpAnd: res = a & b;
      dpPkg::OpEor: res = a ^ b;
      dpPkg::OpSub: begin
        res = a - b;
        c   = a >= b;
        v   = wideOverflow(sa - sb);
      end
      dpPkg::OpRsb: begin
        res = b - a;
        c   = b >= a;
        v   = wideOverflow(sb - sa);
      end
      dpPkg::OpAdd: begin
        res = a + b;
        c   = res < a; // Wrapped past 2^32
        v   = wideOverflow(sa + sb);
      end
      dpPkg::OpOrr: res = a | b;
      dpPkg::OpMov: res = b;
      dpPkg::OpBic: res = a & ~b;
      dpPkg::OpMvn: res = ~b;
      default:      res = '0;
    endcase
    fl = {res[31], res == 32'd0, c, v};
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Drive and model one cycle then check the outputs after the next edge
  task automatic drive(input logic issue, input dpPkg::aluOp_t op, input dpPkg::addrMode_t mode,
                       input dpPkg::imm_t imm, input dpPkg::regIdx_t a, input dpPkg::regIdx_t b,
                       input dpPkg::regIdx_t d, input logic wb, input logic uf);
    dpPkg::word_t  res;
    dpPkg::flags_t fl;
    Issue       = issue;
    AluOp       = op;
    AddrMode    = mode;
    Imm         = imm;
    SrcA        = a;
    SrcB        = b;
    Dest        = d;
    WriteBack   = wb;
    UpdateFlags = uf;
    if (issue) begin
      aluModel(op, modelRegs[a], operandModel(modelRegs[b], imm, mode), res, fl);
      if (wb) modelRegs[d] = res;
      if (uf) modelFlags = fl;
      expResult = res;
      expDest   = d;
    end
    expValid = issue;
    @(posedge Clk);
    #1;
    checkValue("ResultValid", 32'(expValid), 32'(ResultValid));
    if (expValid) begin
      checkValue("Result", expResult, Result);
      checkValue("ResultDest", 32'(expDest), 32'(ResultDest));
    end
    checkValue("Flags", 32'(modelFlags), 32'(Flags));
  endtask

  task automatic idle();
    drive(1'b0, dpPkg::OpMov, dpPkg::AmReg, 12'd0, 4'd0, 4'd0, 4'd0, 1'b0, 1'b0);
  endtask

  task automatic aluCmd(input dpPkg::aluOp_t op, input dpPkg::regIdx_t a,
                        input dpPkg::regIdx_t b, input dpPkg::regIdx_t d);
    drive(1'b1, op, dpPkg::AmReg, 12'd0, a, b, d, 1'b1, 1'b1);
  endtask

  // Full word built from four rotated bytes that forward from step to step
  task automatic loadWord(input dpPkg::regIdx_t d, input dpPkg::word_t w);
    drive(1'b1, dpPkg::OpMov, dpPkg::AmRotImm, {4'd0, w[7:0]}, d, d, d, 1'b1, 1'b0);
    drive(1'b1, dpPkg::OpOrr, dpPkg::AmRotImm, {4'd12, w[15:8]}, d, d, d, 1'b1, 1'b0);
    drive(1'b1, dpPkg::OpOrr, dpPkg::AmRotImm, {4'd8, w[23:16]}, d, d, d, 1'b1, 1'b0);
    drive(1'b1, dpPkg::OpOrr, dpPkg::AmRotImm, {4'd4, w[31:24]}, d, d, d, 1'b1, 1'b0);
  endtask

  initial begin
    seed       = 24;
    errorCount = 0;
    checkCount = 0;
    opList     = '{dpPkg::OpAnd, dpPkg::OpEor, dpPkg::OpSub, dpPkg::OpRsb, dpPkg::OpAdd,
                   dpPkg::OpOrr, dpPkg::OpMov, dpPkg::OpBic, dpPkg::OpMvn};
    for (int i = 0; i < dpPkg::NumRegs; i++) modelRegs[i] = '0;
    modelFlags  = '0;
    expValid    = 1'b0;
    expResult   = '0;
    expDest     = '0;
    amt         = '0;
    r           = '0;
    Reset       = 1'b1;
    Issue       = 1'b0;
    WriteBack   = 1'b0;
    UpdateFlags = 1'b0;
    AluOp       = dpPkg::OpMov;
    AddrMode    = dpPkg::AmReg;
    Imm         = '0;
    SrcA        = '0;
    SrcB        = '0;
    Dest        = '0;
    repeat (4) @(posedge Clk);
    #1;
    Reset = 1'b0;

    // Quiet pipeline and zero registers after reset
    idle();
    idle();
    for (int i = 0; i < dpPkg::NumRegs; i++) begin
      drive(1'b1, dpPkg::OpMov, dpPkg::AmReg, 12'd0, 4'd0, 4'(i), 4'(i), 1'b1, 1'b0);
    end

    for (int i = 0; i < 32; i++) begin
      r = nextRandom();
      drive(1'b1, r[0] ? dpPkg::OpMvn : dpPkg::OpMov, r[1] ? dpPkg::AmZeroImm : dpPkg::AmRotImm,
            r[31:20], 4'd0, 4'd0, r[7:4], 1'b1, r[2]);
    end

    // All opcodes on fresh random register contents
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < dpPkg::NumRegs; i++) loadWord(4'(i), nextRandom());
      for (int i = 0; i < 27; i++) begin
        r = nextRandom();
        drive(1'b1, opList[i % 9], dpPkg::AmReg, 12'd0, r[3:0], r[7:4], r[11:8], 1'b1, 1'b1);
      end
    end

    loadWord(4'd1, 32'h7FFF_FFFF);
    loadWord(4'd2, 32'h0000_0001);
    loadWord(4'd4, 32'hFFFF_FFFF);
    loadWord(4'd9, 32'h8000_0000);
    aluCmd(dpPkg::OpAdd, 4'd1, 4'd2, 4'd3);  // Positive overflow
    aluCmd(dpPkg::OpAdd, 4'd4, 4'd2, 4'd5);  // Carry out and zero
    aluCmd(dpPkg::OpSub, 4'd2, 4'd4, 4'd6);  // Borrow
    aluCmd(dpPkg::OpSub, 4'd1, 4'd1, 4'd7);  // Zero without borrow
    aluCmd(dpPkg::OpSub, 4'd9, 4'd2, 4'd10); // Negative overflow
    aluCmd(dpPkg::OpRsb, 4'd2, 4'd9, 4'd11);
    aluCmd(dpPkg::OpAnd, 4'd4, 4'd9, 4'd12);

    // Every shift type with amount zero in a third of the runs
    for (int i = 0; i < 48; i++) begin
      r   = nextRandom();
      amt = ((i / 4) % 3 == 0) ? 5'd0 : r[20:16];
      drive(1'b1, dpPkg::OpMov, dpPkg::AmShiftReg, {amt, 2'(i), r[4:0]}, 4'd0, r[7:4],
            r[11:8], 1'b1, 1'b1);
    end

    // Dense hazards on four registers with mixed write-back and flag control
    for (int i = 0; i < 200; i++) begin
      r = nextRandom();
      drive(r[31:29] != 3'd0, opList[int'(r[28:25]) % 9], r[9:8], r[21:10], {2'b0, r[1:0]},
            {2'b0, r[3:2]}, {2'b0, r[5:4]}, r[23:22] != 2'd0, r[24]);
    end

    loadWord(4'd5, 32'h1234_5678);
    drive(1'b1, dpPkg::OpMvn, dpPkg::AmReg, 12'd0, 4'd0, 4'd5, 4'd5, 1'b0, 1'b1);
    drive(1'b1, dpPkg::OpMov, dpPkg::AmReg, 12'd0, 4'd0, 4'd5, 4'd6, 1'b1, 1'b0);
    idle();
    drive(1'b1, dpPkg::OpMov, dpPkg::AmReg, 12'd0, 4'd0, 4'd5, 4'd7, 1'b1, 1'b0);

    for (int n = 0; ResultValid || n < 2; n++) begin
      if (n == 8) begin
        $display("Timeout waiting for the pipeline to drain");
        errorCount++;
        break;
      end
      idle();
    end

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/alu.sv ====
// Data-processing ALU with next-flag generation
// Logical ops keep C and V from the flag register
`timescale 1ns/1ps

module alu (
  input  dpPkg::word_t   A,
  input  dpPkg::word_t   B,
  input  dpPkg::aluOp_t  AluOp,
  input  dpPkg::flags_t  FlagsIn,
  output dpPkg::word_t   Result,
  output dpPkg::flags_t  FlagsOut
);

  logic         isRsb;
  dpPkg::word_t minuend;
  dpPkg::word_t subtrahend;
  logic [32:0]  addSum;    // Bit 32 is carry out
  logic [32:0]  subDiff;   // Bit 32 is borrow
  logic         addOvf;
  logic         subOvf;
  logic         carry;
  logic         overflow;

  // SUB and RSB share one subtractor with swapped inputs
  assign isRsb      = (AluOp == dpPkg::OpRsb);
  assign minuend    = isRsb ? B : A;
  assign subtrahend = isRsb ? A : B;

  assign addSum  = {1'b0, A} + {1'b0, B};
  assign subDiff = {1'b0, minuend} - {1'b0, subtrahend};

  // Signed overflow
  assign addOvf = (A[31] == B[31]) && (addSum[31] != A[31]);
  assign subOvf = (minuend[31] != subtrahend[31]) && (subDiff[31] != minuend[31]);

  always_comb begin
    carry    = FlagsIn[dpPkg::FlagC];
    overflow = FlagsIn[dpPkg::FlagV];
    case (AluOp)
      dpPkg::OpAnd: Result = A & B;
      dpPkg::OpEor: Result = A ^ B;
      dpPkg::OpSub, dpPkg::OpRsb: begin
        Result   = subDiff[31:0];
        carry    = ~subDiff[32]; // Set when no borrow
        overflow = subOvf;
      end
      dpPkg::OpAdd: begin
        Result   = addSum[31:0];
        carry    = addSum[32];
        overflow = addOvf;
      end
      dpPkg::OpOrr: Result = A | B;
      dpPkg::OpMov: Result = B;
      dpPkg::OpBic: Result = A & ~B;
      dpPkg::OpMvn: Result = ~B;
      default:      Result = '0; // ADC, SBC, RSC and compares not supported
    endcase
  end

  always_comb begin
    FlagsOut               = '0;
    FlagsOut[dpPkg::FlagN] = Result[31];
    FlagsOut[dpPkg::FlagZ] = (Result == '0);
    FlagsOut[dpPkg::FlagC] = carry;
    FlagsOut[dpPkg::FlagV] = overflow;
  end

endmodule

// ==== logic/dpCore.sv ====
// Top level of the data-processing datapath
// One command per Issue pulse, result reported one cycle later
`timescale 1ns/1ps

module dpCore (
  input  logic             Clk,
  input  logic             Reset,
  input  logic             Issue,
  input  logic             WriteBack,
  input  logic             UpdateFlags,
  input  dpPkg::aluOp_t    AluOp,
  input  dpPkg::addrMode_t AddrMode,
  input  dpPkg::imm_t      Imm,
  input  dpPkg::regIdx_t   SrcA,
  input  dpPkg::regIdx_t   SrcB,
  input  dpPkg::regIdx_t   Dest,
  output logic             ResultValid,
  output dpPkg::word_t     Result,
  output dpPkg::regIdx_t   ResultDest,
  output dpPkg::flags_t    Flags
);

  dpPkg::word_t  regDataA;
  dpPkg::word_t  regDataB;
  dpPkg::word_t  operandA;
  dpPkg::word_t  operandB;   // Forwarded Rm
  dpPkg::word_t  shiftedB;
  dpPkg::word_t  aluResult;
  dpPkg::flags_t aluFlags;
  logic          stageWrite;

  regFile regs (
    .Clk       (Clk),
    .Reset     (Reset),
    .WriteEn   (stageWrite),
    .WriteIdx  (ResultDest),
    .WriteData (Result),
    .ReadIdxA  (SrcA),
    .ReadIdxB  (SrcB),
    .ReadDataA (regDataA),
    .ReadDataB (regDataB)
  );

  forwardUnit fwd (
    .RegDataA    (regDataA),
    .RegDataB    (regDataB),
    .SrcA        (SrcA),
    .SrcB        (SrcB),
    .StageWrite  (stageWrite),
    .StageDest   (ResultDest),
    .StageResult (Result),
    .OperandA    (operandA),
    .OperandB    (operandB)
  );

  shifter shift (
    .Rm       (operandB),
    .Imm      (Imm),
    .AddrMode (AddrMode),
    .Operand  (shiftedB)
  );

  alu alu0 (
    .A        (operandA),
    .B        (shiftedB),
    .AluOp    (AluOp),
    .FlagsIn  (Flags),
    .Result   (aluResult),
    .FlagsOut (aluFlags)
  );

  executeStage exec (
    .Clk         (Clk),
    .Reset       (Reset),
    .Issue       (Issue),
    .WriteBack   (WriteBack),
    .UpdateFlags (UpdateFlags),
    .Dest        (Dest),
    .AluResult   (aluResult),
    .AluFlags    (aluFlags),
    .ResultValid (ResultValid),
    .Result      (Result),
    .ResultDest  (ResultDest),
    .StageWrite  (stageWrite),
    .Flags       (Flags)
  );

endmodule

// ==== logic/dpPkg.sv ====
// Shared widths, types and encodings for the data-processing datapath
// Modules refer to these by scoped name, dpPkg::name
package dpPkg;

  localparam int WordWidth = 32;
  localparam int NumRegs   = 16;

  typedef logic [WordWidth-1:0] word_t;   // Data word
  typedef logic [3:0]           regIdx_t; // Register number
  typedef logic [11:0]          imm_t;    // Immediate field of a command
  typedef logic [3:0]           aluOp_t;  // ARM data-processing opcode
  typedef logic [1:0]           addrMode_t;
  typedef logic [3:0]           flags_t;  // N, Z, C, V from bit 3 down

  // Opcodes, ARM encoding
  localparam aluOp_t OpAnd = 4'd0;
  localparam aluOp_t OpEor = 4'd1;
  localparam aluOp_t OpSub = 4'd2;
  localparam aluOp_t OpRsb = 4'd3;
  localparam aluOp_t OpAdd = 4'd4;
  localparam aluOp_t OpOrr = 4'd12;
  localparam aluOp_t OpMov = 4'd13;
  localparam aluOp_t OpBic = 4'd14;
  localparam aluOp_t OpMvn = 4'd15;

  // Second-operand addressing modes
  localparam addrMode_t AmRotImm   = 2'd0; // 8-bit immediate, rotated
  localparam addrMode_t AmReg      = 2'd1; // Register as is
  localparam addrMode_t AmZeroImm  = 2'd2; // 12-bit immediate, zero-extended
  localparam addrMode_t AmShiftReg = 2'd3; // Register shifted by immediate amount

  // Shift types in Imm[6:5]
  localparam logic [1:0] ShLsl = 2'd0;
  localparam logic [1:0] ShLsr = 2'd1;
  localparam logic [1:0] ShAsr = 2'd2;
  localparam logic [1:0] ShRor = 2'd3;

  // Bit positions inside flags_t
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

endpackage

// ==== logic/executeStage.sv ====
// Execute stage register and flag register
// Holds one result for a cycle, then it is written back and can be forwarded
`timescale 1ns/1ps

module executeStage (
  input  logic           Clk,
  input  logic           Reset,
  input  logic           Issue,
  input  logic           WriteBack,
  input  logic           UpdateFlags,
  input  dpPkg::regIdx_t Dest,
  input  dpPkg::word_t   AluResult,
  input  dpPkg::flags_t  AluFlags,
  output logic           ResultValid,
  output dpPkg::word_t   Result,
  output dpPkg::regIdx_t ResultDest,
  output logic           StageWrite,
  output dpPkg::flags_t  Flags
);

  logic           stageValid;
  logic           stageWb;     // Write-back requested by the held command
  dpPkg::word_t   stageResult;
  dpPkg::regIdx_t stageDest;
  dpPkg::flags_t  flagReg;

  // Stage register, loaded every cycle so a held item lives exactly one cycle
  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      stageValid  <= 1'b0;
      stageWb     <= 1'b0;
      stageResult <= '0;
      stageDest   <= '0;
    end else begin
      stageValid  <= Issue;
      stageWb     <= WriteBack;
      stageResult <= AluResult;
      stageDest   <= Dest;
    end
  end

  // Flag register
  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      flagReg <= '0;
    end else if (Issue && UpdateFlags) begin
      flagReg <= AluFlags;
    end
  end

  assign ResultValid = stageValid;
  assign Result      = stageResult;
  assign ResultDest  = stageDest;
  assign StageWrite  = stageValid && stageWb; // Register file write and bypass enable
  assign Flags       = flagReg;

endmodule

// ==== logic/forwardUnit.sv ====
// Operand bypass from the execute stage register
// A source that matches the in-flight destination takes the stage result
`timescale 1ns/1ps

module forwardUnit (
  input  dpPkg::word_t   RegDataA,
  input  dpPkg::word_t   RegDataB,
  input  dpPkg::regIdx_t SrcA,
  input  dpPkg::regIdx_t SrcB,
  input  logic           StageWrite,
  input  dpPkg::regIdx_t StageDest,
  input  dpPkg::word_t   StageResult,
  output dpPkg::word_t   OperandA,
  output dpPkg::word_t   OperandB
);

  logic hitA;
  logic hitB;

  // The value in the stage register reaches the register file only at the next edge,
  // so a reader in this cycle must take it from the stage
  function automatic logic matchStage(
    input logic           stageWrite,
    input dpPkg::regIdx_t stageDest,
    input dpPkg::regIdx_t src
  );
    return stageWrite && (stageDest == src);
  endfunction

  assign hitA = matchStage(StageWrite, StageDest, SrcA);
  assign hitB = matchStage(StageWrite, StageDest, SrcB);

  assign OperandA = hitA ? StageResult : RegDataA; // Bypass or file value
  assign OperandB = hitB ? StageResult : RegDataB;

endmodule

// ==== logic/regFile.sv ====
// Sixteen-word register file, one write port and two combinational read ports
// Written from the execute stage one cycle after a result is reported
`timescale 1ns/1ps

module regFile (
  input  logic          Clk,
  input  logic          Reset,
  input  logic          WriteEn,
  input  dpPkg::regIdx_t WriteIdx,
  input  dpPkg::word_t   WriteData,
  input  dpPkg::regIdx_t ReadIdxA,
  input  dpPkg::regIdx_t ReadIdxB,
  output dpPkg::word_t   ReadDataA,
  output dpPkg::word_t   ReadDataB
);

  dpPkg::word_t regs [dpPkg::NumRegs];
  logic [dpPkg::NumRegs-1:0] loadEn; // One-hot write select

  // Write decoder
  always_comb begin
    loadEn = '0;
    if (WriteEn) begin
      loadEn[WriteIdx] = 1'b1;
    end
  end

  // One register per entry, R15 included
  for (genvar i = 0; i < dpPkg::NumRegs; i++) begin : genRegs
    always_ff @(posedge Clk or posedge Reset) begin
      if (Reset) begin
        regs[i] <= '0;
      end else if (loadEn[i]) begin
        regs[i] <= WriteData;
      end
    end
  end

  // Read muxes
  assign ReadDataA = regs[ReadIdxA];
  assign ReadDataB = regs[ReadIdxB];

endmodule

// ==== logic/shifter.sv ====
// Second-operand former, four ARM-style addressing modes
// Takes the forwarded Rm value and the 12-bit immediate of the command
`timescale 1ns/1ps

module shifter (
  input  dpPkg::word_t     Rm,
  input  dpPkg::imm_t      Imm,
  input  dpPkg::addrMode_t AddrMode,
  output dpPkg::word_t     Operand
);

  logic [7:0]   immByte;
  logic [4:0]   rotAmt;    // Twice Imm[11:8]
  logic [4:0]   shAmt;
  logic [1:0]   shType;
  logic [63:0]  immPair;   // Doubled byte for rotation
  logic [63:0]  rmPair;    // Doubled Rm for rotation
  logic [63:0]  immRot;
  logic [63:0]  rmRot;
  dpPkg::word_t rotImm;
  dpPkg::word_t shifted;

  assign immByte = Imm[7:0];
  assign rotAmt  = {Imm[11:8], 1'b0};
  assign shAmt   = Imm[11:7];
  assign shType  = Imm[6:5];

  // Rotate right as a shift of the value placed twice side by side
  assign immPair = {24'b0, immByte, 24'b0, immByte};
  assign immRot  = immPair >> rotAmt;
  assign rotImm  = immRot[31:0];

  assign rmPair  = {Rm, Rm};
  assign rmRot   = rmPair >> shAmt;

  // Amount zero gives Rm back for every type
  always_comb begin
    case (shType)
      dpPkg::ShLsl: shifted = Rm << shAmt;
      dpPkg::ShLsr: shifted = Rm >> shAmt;
      dpPkg::ShAsr: shifted = dpPkg::word_t'($signed(Rm) >>> shAmt); // Sign fill
      dpPkg::ShRor: shifted = rmRot[31:0];
      default:      shifted = Rm;
    endcase
  end

  always_comb begin
    case (AddrMode)
      dpPkg::AmRotImm:   Operand = rotImm;
      dpPkg::AmReg:      Operand = Rm;
      dpPkg::AmZeroImm:  Operand = {20'b0, Imm};
      dpPkg::AmShiftReg: Operand = shifted;
      default:           Operand = Rm;
    endcase
  end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module dpCoreTb -Mdir obj_dir -o dpCoreSim
output=$(./obj_dir/dpCoreSim 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "TB PASSED"

// ==== src.f ====
logic/dpPkg.sv
logic/regFile.sv
logic/forwardUnit.sv
logic/shifter.sv
logic/alu.sv
logic/executeStage.sv
logic/dpCore.sv
dv/dpCoreChecker.sv
dv/dpCoreTb.sv
